// File: verilog/simf_alu_cfg.svh
`ifndef SIMF_ALU_CFG_SVH
`define SIMF_ALU_CFG_SVH

`define SIMF_DATA_W      32  // Operand width
`define SIMF_EXP_W       8   // Single exponent field

// Control word layout
`define SIMF_FMT_W       8
`define SIMF_OP_W        12
`define SIMF_FMT_MSB     31
`define SIMF_FMT_LSB     24
`define SIMF_OP_MSB      11

`define SIMF_PIPE_DEPTH  3   // Start to done, in cycles

`endif

// File: verilog/simf_isa_pkg.sv
`include "simf_alu_cfg.svh"

package simf_isa_pkg;

   typedef logic [`SIMF_FMT_W-1:0] fmt_t;   // Format field of the control word
   typedef logic [`SIMF_OP_W-1:0]  opcode_t;

   // One-hot format codes as the instruction decoder sends them
   localparam fmt_t FMT_VOP1  = 8'h01;
   localparam fmt_t FMT_VOP2  = 8'h02;
   localparam fmt_t FMT_VOPC  = 8'h04;
   localparam fmt_t FMT_VOP3A = 8'h08;

   localparam opcode_t OP_V_MAX          = 12'h010;  // V_MAX_F32, VOP2
   localparam opcode_t OP_CMP_BASE_VOPC  = 12'h000;  // First V_CMP_*_F32
   localparam opcode_t OP_CMP_BASE_VOP3A = 12'h000;

   typedef enum logic [1:0] {
      CLS_NOP,
      CLS_CMP,
      CLS_MAX
   } alu_class_e;

   // Same order as the compare opcodes
   typedef enum logic [3:0] {
      COND_F,
      COND_LT,
      COND_EQ,
      COND_LE,
      COND_GT,
      COND_LG,
      COND_GE,
      COND_O,
      COND_U,
      COND_NGE,
      COND_NLG,
      COND_NGT,
      COND_NLE,
      COND_NEQ,
      COND_NLT,
      COND_TRU
   } cmp_cond_e;

endpackage

// File: verilog/simf_alu_pkg.sv
`include "simf_alu_cfg.svh"

package simf_alu_pkg;
   import simf_isa_pkg::*;

   typedef logic [`SIMF_DATA_W-1:0] fp32_t;      // Raw single-precision bits
   typedef logic [`SIMF_FMT_MSB:0]  ctrl_word_t;

   // Stage 1 to stage 2
   typedef struct packed {
      alu_class_e cls;
      cmp_cond_e  cond;
      fp32_t      src1;
      fp32_t      src2;
      logic       vcc_in;
      logic       exec;
   } dec_pkt_t;

   // Stage 2 to stage 3
   typedef struct packed {
      alu_class_e cls;
      cmp_cond_e  cond;
      logic       lt;       // src1 < src2, ordered only
      logic       eq;       // src1 == src2, ordered only
      logic       unord;    // At least one NaN
      fp32_t      max_val;
      logic       vcc_in;
      logic       exec;
   } cmp_pkt_t;

endpackage

// File: verilog/simf_decode.sv
`timescale 1ns/1ns
`include "simf_alu_cfg.svh"

module simf_decode
   import simf_isa_pkg::*, simf_alu_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n_i,
   input  logic       start_i,
   input  ctrl_word_t control_i,
   input  fp32_t      src1_i,
   input  fp32_t      src2_i,
   input  logic       vcc_i,
   input  logic       exec_i,
   output logic       dec_valid_o,
   output dec_pkt_t   dec_pkt_o
);

   fmt_t       fmt;
   opcode_t    opcode;
   opcode_t    cmp_rel;   // Offset from the compare base
   alu_class_e cls;
   cmp_cond_e  cond;

   assign fmt    = control_i[`SIMF_FMT_MSB:`SIMF_FMT_LSB];
   assign opcode = control_i[`SIMF_OP_MSB:0];

   // Both compare encodings share the condition order and the base
   assign cmp_rel = opcode - OP_CMP_BASE_VOPC;
   assign cond    = cmp_cond_e'(cmp_rel[3:0]);

   always_comb
   begin
      cls = CLS_NOP;
      case (fmt)
         FMT_VOPC, FMT_VOP3A:
         begin
            if (cmp_rel[`SIMF_OP_W-1:4] == '0)   // Sixteen compare codes
            begin
               cls = CLS_CMP;
            end
         end
         FMT_VOP2:
         begin
            if (opcode == OP_V_MAX)
            begin
               cls = CLS_MAX;
            end
         end
         FMT_VOP1: cls = CLS_NOP;   // Only FPU ops in VOP1
         default:  cls = CLS_NOP;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         dec_valid_o <= 1'b0;
      end
      else
      begin
         dec_valid_o <= start_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (start_i)
      begin
         dec_pkt_o.cls    <= cls;
         dec_pkt_o.cond   <= cond;
         dec_pkt_o.src1   <= src1_i;
         dec_pkt_o.src2   <= src2_i;
         dec_pkt_o.vcc_in <= vcc_i;
         dec_pkt_o.exec   <= exec_i;
      end
   end

endmodule

// File: verilog/simf_fcmp_stage.sv
`timescale 1ns/1ns
`include "simf_alu_cfg.svh"

module simf_fcmp_stage
   import simf_alu_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n_i,
   input  logic     dec_valid_i,
   input  dec_pkt_t dec_pkt_i,
   output logic     cmp_valid_o,
   output cmp_pkt_t cmp_pkt_o
);

   localparam int MAG_W = `SIMF_DATA_W - 1;

   // All-ones exponent with a nonzero mantissa
   function automatic logic is_nan(input fp32_t f);
      logic [`SIMF_EXP_W-1:0]              exp_f;
      logic [`SIMF_DATA_W-`SIMF_EXP_W-2:0] man_f;
      exp_f = f[`SIMF_DATA_W-2 -: `SIMF_EXP_W];
      man_f = f[`SIMF_DATA_W-`SIMF_EXP_W-2:0];
      return (&exp_f) && (|man_f);
   endfunction

   fp32_t            a;
   fp32_t            b;
   logic [MAG_W-1:0] mag_a;
   logic [MAG_W-1:0] mag_b;
   logic             sign_a;
   logic             sign_b;
   logic             a_nan;
   logic             b_nan;
   logic             unord;
   logic             both_zero;
   logic             lt;
   logic             eq;
   fp32_t            max_val;

   assign a      = dec_pkt_i.src1;
   assign b      = dec_pkt_i.src2;
   assign sign_a = a[`SIMF_DATA_W-1];
   assign sign_b = b[`SIMF_DATA_W-1];
   assign mag_a  = a[MAG_W-1:0];
   assign mag_b  = b[MAG_W-1:0];

   assign a_nan     = is_nan(a);
   assign b_nan     = is_nan(b);
   assign unord     = a_nan | b_nan;
   assign both_zero = (mag_a == '0) && (mag_b == '0);   // +0 equals -0

   always_comb
   begin
      lt = 1'b0;
      eq = 1'b0;
      if (unord)
      begin
         lt = 1'b0;
         eq = 1'b0;
      end
      else if (both_zero)
      begin
         eq = 1'b1;
      end
      else if (sign_a != sign_b)
      begin
         lt = sign_a;   // The negative one is smaller
      end
      else
      begin
         eq = (mag_a == mag_b);
         // Magnitude order flips for negatives
         lt = sign_a ? (mag_a > mag_b) : (mag_a < mag_b);
      end
   end

   // V_MAX picks the non-NaN side, src2 when both are NaN
   always_comb
   begin
      if (a_nan)
      begin
         max_val = b;
      end
      else if (b_nan)
      begin
         max_val = a;
      end
      else
      begin
         max_val = lt ? b : a;   // Ties keep src1
      end
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cmp_valid_o <= 1'b0;
      end
      else
      begin
         cmp_valid_o <= dec_valid_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (dec_valid_i)
      begin
         cmp_pkt_o.cls     <= dec_pkt_i.cls;
         cmp_pkt_o.cond    <= dec_pkt_i.cond;
         cmp_pkt_o.lt      <= lt;
         cmp_pkt_o.eq      <= eq;
         cmp_pkt_o.unord   <= unord;
         cmp_pkt_o.max_val <= max_val;
         cmp_pkt_o.vcc_in  <= dec_pkt_i.vcc_in;
         cmp_pkt_o.exec    <= dec_pkt_i.exec;
      end
   end

endmodule

// File: verilog/simf_result_stage.sv
`timescale 1ns/1ns

module simf_result_stage
   import simf_isa_pkg::*, simf_alu_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n_i,
   input  logic     cmp_valid_i,
   input  cmp_pkt_t cmp_pkt_i,
   output logic     done_o,
   output fp32_t    vgpr_data_o,
   output logic     vcc_o
);

   logic       gt;
   logic [2:0] rel;        // {gt, eq, lt}
   logic [3:0] cond_bits;
   logic [2:0] cond_sel;
   logic       cond_true;
   logic       vcc_nxt;
   fp32_t      vgpr_nxt;

   assign gt  = ~cmp_pkt_i.lt & ~cmp_pkt_i.eq & ~cmp_pkt_i.unord;
   assign rel = {gt, cmp_pkt_i.eq, cmp_pkt_i.lt};

   // Codes 0-7 OR the relations they accept, F through O.
   // Codes 8-15 are the complements of 15-code, U through TRU.
   assign cond_bits = cmp_pkt_i.cond;
   assign cond_sel  = cond_bits[3] ? ~cond_bits[2:0] : cond_bits[2:0];
   assign cond_true = cond_bits[3] ^ (|(cond_sel & rel));

   always_comb
   begin
      vcc_nxt  = cmp_pkt_i.vcc_in;   // Lane off or no compare
      vgpr_nxt = '0;
      if (cmp_pkt_i.exec)
      begin
         case (cmp_pkt_i.cls)
            CLS_CMP: vcc_nxt  = cond_true;
            CLS_MAX: vgpr_nxt = cmp_pkt_i.max_val;
            default: vcc_nxt  = cmp_pkt_i.vcc_in;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         done_o      <= 1'b0;
         vcc_o       <= 1'b0;
         vgpr_data_o <= '0;
      end
      else
      begin
         done_o      <= cmp_valid_i;
         vcc_o       <= cmp_valid_i ? vcc_nxt : 1'b0;   // Zero between results
         vgpr_data_o <= cmp_valid_i ? vgpr_nxt : '0;
      end
   end

endmodule

// File: verilog/simf_alu.sv
`timescale 1ns/1ns

module simf_alu
   import simf_alu_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n_i,
   input  logic       start_i,
   input  ctrl_word_t control_i,
   input  fp32_t      src1_i,
   input  fp32_t      src2_i,
   input  logic       vcc_i,
   input  logic       exec_i,
   output logic       done_o,
   output fp32_t      vgpr_data_o,
   output logic       vcc_o
);

   logic     dec_valid;
   dec_pkt_t dec_pkt;
   logic     cmp_valid;
   cmp_pkt_t cmp_pkt;

   simf_decode u_decode (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .start_i     (start_i),
      .control_i   (control_i),
      .src1_i      (src1_i),
      .src2_i      (src2_i),
      .vcc_i       (vcc_i),
      .exec_i      (exec_i),
      .dec_valid_o (dec_valid),
      .dec_pkt_o   (dec_pkt)
   );

   simf_fcmp_stage u_fcmp (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .dec_valid_i (dec_valid),
      .dec_pkt_i   (dec_pkt),
      .cmp_valid_o (cmp_valid),
      .cmp_pkt_o   (cmp_pkt)
   );

   simf_result_stage u_result (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .cmp_valid_i (cmp_valid),
      .cmp_pkt_i   (cmp_pkt),
      .done_o      (done_o),
      .vgpr_data_o (vgpr_data_o),
      .vcc_o       (vcc_o)
   );

endmodule

// File: dv/simf_alu_asserts.sv
`timescale 1ns/1ns
`include "simf_alu_cfg.svh"

module simf_alu_asserts
   import simf_alu_pkg::*;
(
   input logic  clk,
   input logic  arst_n_i,
   input logic  start_i,
   input logic  done_o,
   input fp32_t vgpr_data_o
);

   int since_rst;   // Cycles since reset release, saturating

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         since_rst <= 0;
      end
      else if (since_rst < `SIMF_PIPE_DEPTH)
      begin
         since_rst <= since_rst + 1;
      end
   end

   done_quiet: assert property (@(posedge clk) (since_rst < `SIMF_PIPE_DEPTH) |-> !done_o)
      else $error("done_o high during reset or before the pipeline could fill");

   // Pipeline is fixed length
   done_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
      (since_rst >= `SIMF_PIPE_DEPTH) |-> (done_o == $past(start_i, `SIMF_PIPE_DEPTH)))
      else $error("done_o does not follow start_i by the pipeline depth");

   vgpr_idle_zero: assert property (@(posedge clk) !done_o |-> (vgpr_data_o == '0))
      else $error("vgpr_data_o nonzero while done_o is low");

endmodule

bind simf_alu simf_alu_asserts u_asserts (
   .clk         (clk),
   .arst_n_i    (arst_n_i),
   .start_i     (start_i),
   .done_o      (done_o),
   .vgpr_data_o (vgpr_data_o)
);

// File: dv/simf_alu_tb.sv
`timescale 1ns/1ns
`include "simf_alu_cfg.svh"

module simf_alu_tb
   import simf_alu_pkg::*;
();

   localparam int RST_CYCLES = 5;
   localparam int DRIVE_DLY  = 5;    // Input skew after the rising edge
   localparam int WAIT_LIMIT = 100;  // Cycles before a drain gives up

   typedef struct packed {
      logic [8*16-1:0] name;
      logic            vcc;
      fp32_t           vgpr;
      logic [31:0]     cyc;   // Cycle count when done_o is due
   } exp_t;

   logic       clk;
   logic       arst_n_i;
   logic       start_i;
   ctrl_word_t control_i;
   fp32_t      src1_i;
   fp32_t      src2_i;
   logic       vcc_i;
   logic       exec_i;
   logic       done_o;
   fp32_t      vgpr_data_o;
   logic       vcc_o;

   exp_t        exp_q[$];
   exp_t        mon_exp;
   int          cyc;
   int          n_done;
   logic [31:0] seed;

   simf_alu dut0 (
      .clk         (clk),
      .arst_n_i    (arst_n_i),
      .start_i     (start_i),
      .control_i   (control_i),
      .src1_i      (src1_i),
      .src2_i      (src2_i),
      .vcc_i       (vcc_i),
      .exec_i      (exec_i),
      .done_o      (done_o),
      .vgpr_data_o (vgpr_data_o),
      .vcc_o       (vcc_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cyc <= cyc + 1;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic check(input logic [8*16-1:0] name, input logic [31:0] exp_v,
                        input logic [31:0] act_v);
      if (exp_v !== act_v)
      begin
         $display("ERR %0s expected %h actual %h", name, exp_v, act_v);
         $display("Some tests failed");
         $fatal(1);
      end
   endtask

   // Outputs are settled by the falling edge
   always @(negedge clk)
   begin
      if (arst_n_i && done_o)
      begin
         if (exp_q.size() == 0)
         begin
            $display("done_o pulsed while no operation was outstanding");
            $display("Some tests failed");
            $fatal(1);
         end
         else
         begin
            mon_exp = exp_q.pop_front();
            check(mon_exp.name, mon_exp.cyc, cyc);   // Latency and order
            check(mon_exp.name, {31'b0, mon_exp.vcc}, {31'b0, vcc_o});
            check(mon_exp.name, mon_exp.vgpr, vgpr_data_o);
            n_done++;
         end
      end
      else if (arst_n_i)
      begin
         check("idle_vcc", 32'd0, {31'b0, vcc_o});   // Zero between results
      end
   end

   initial
   begin : main
      int              fd;
      int              n;
      int              idle;
      int              wait_cnt;
      string           line;
      logic [8*16-1:0] name;
      logic [31:0]     ctrl;
      logic [31:0]     s1;
      logic [31:0]     s2;
      logic [31:0]     v_vcc;
      logic [31:0]     v_exec;
      logic [31:0]     e_vcc;
      logic [31:0]     e_vgpr;
      exp_t            e;
      arst_n_i  = 1'b0;
      start_i   = 1'b0;
      control_i = '0;
      src1_i    = '0;
      src2_i    = '0;
      vcc_i     = 1'b0;
      exec_i    = 1'b0;
      cyc       = 0;
      n_done    = 0;
      seed      = 32'h80d9;

      for (int i = 0; i < RST_CYCLES; i++)
      begin
         @(posedge clk);
      end
      #DRIVE_DLY arst_n_i = 1'b1;

      fd = $fopen("dv/simf_alu_cases.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the stimulus file dv/simf_alu_cases.txt");
         $display("Some tests failed");
         $fatal(1);
      end

      while (!$feof(fd))
      begin
         line = "";
         n    = $fgets(line, fd);
         if (n > 0 && line.len() > 1 && line.getc(0) != "#")
         begin
            n = $sscanf(line, "%s %h %h %h %h %h %h %h",
                        name, ctrl, s1, s2, v_vcc, v_exec, e_vcc, e_vgpr);
            if (n != 8)
            begin
               $display("Malformed line in the stimulus file: %s", line);
               $display("Some tests failed");
               $fatal(1);
            end
            idle = int'((seed >> 16) % 32'd3);   // 0 to 2 gap cycles
            seed = lcg_next(seed);
            for (int k = 0; k < idle; k++)
            begin
               start_i = 1'b0;
               @(posedge clk);
               #DRIVE_DLY;
            end
            start_i   = 1'b1;
            control_i = ctrl;
            src1_i    = s1;
            src2_i    = s2;
            vcc_i     = v_vcc[0];
            exec_i    = v_exec[0];
            e.name    = name;
            e.vcc     = e_vcc[0];
            e.vgpr    = e_vgpr;
            e.cyc     = cyc + `SIMF_PIPE_DEPTH;
            exp_q.push_back(e);
            @(posedge clk);
            #DRIVE_DLY;
            start_i = 1'b0;
         end
      end
      $fclose(fd);

      wait_cnt = 0;
      while (exp_q.size() != 0 && wait_cnt < WAIT_LIMIT)
      begin
         @(posedge clk);
         wait_cnt++;
      end

      if (exp_q.size() != 0)
      begin
         $display("Timed out waiting for %0d outstanding results", exp_q.size());
         $display("Some tests failed");
         $fatal(1);
      end
      else if (n_done == 0)
      begin
         $display("No test cases were read from the stimulus file");
         $display("Some tests failed");
         $fatal(1);
      end
      else
      begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

// File: dv/simf_alu_cases.txt
# name control src1 src2 vcc_i exec_i exp_vcc exp_vgpr, all values in hex
# control holds the format in bits 31:24 and the opcode in bits 11:0
lt_neg 04000001 c0000000 bf800000 0 1 1 00000000
lt_neg_false 04000001 bf800000 c0000000 1 1 0 00000000
le_equal 04000003 3f800000 3f800000 0 1 1 00000000
gt_mixed 04000004 3f000000 c0600000 0 1 1 00000000
ge_neg 04000006 c0600000 bf800000 1 1 0 00000000
eq_pos 04000002 40000000 40000000 0 1 1 00000000
lg_vop3 08000005 3f800000 40000000 0 1 1 00000000
lt_vop3 08000001 bf800000 3f800000 0 1 1 00000000
gt_vop3_neg 08000004 c0000000 c0600000 0 1 1 00000000
eq_zeros 04000002 00000000 80000000 0 1 1 00000000
lt_zeros 04000001 80000000 00000000 1 1 0 00000000
eq_nan 04000002 7fc00000 7fc00000 1 1 0 00000000
o_nan 04000007 3f800000 7fc00000 1 1 0 00000000
u_nan 04000008 7fc00000 3f800000 0 1 1 00000000
neq_nan 0400000d 7fc00000 3f800000 0 1 1 00000000
nge_nan_vop3 08000009 3f800000 ffc00000 0 1 1 00000000
nlt_ordered 0400000e 3f800000 40000000 1 1 0 00000000
nlg_equal 0400000a 3f800000 3f800000 0 1 1 00000000
ngt_ordered 0400000b 40000000 3f800000 1 1 0 00000000
nle_ordered 0400000c 40000000 3f800000 0 1 1 00000000
o_ordered 04000007 bf800000 3f800000 0 1 1 00000000
f_nan 04000000 7fc00000 3f800000 1 1 0 00000000
tru_nan 0800000f 7fc00000 7fc00000 0 1 1 00000000
max_pos 02000010 3f800000 40000000 1 1 1 40000000
max_neg 02000010 c0000000 bf800000 0 1 0 bf800000
max_nan_src1 02000010 7fc00000 c0600000 1 1 1 c0600000
max_nan_src2 02000010 3f000000 7fc00000 0 1 0 3f000000
max_zeros 02000010 80000000 00000000 0 1 0 80000000
exec_off_cmp 04000001 bf800000 3f800000 0 0 0 00000000
exec_off_max 02000010 3f800000 40000000 1 0 1 00000000
add_f32 02000003 3f800000 40000000 1 1 1 00000000
vop1_cvt 01000005 3f800000 40000000 0 1 0 00000000
cmp_out_range 04000020 3f800000 40000000 1 1 1 00000000

// File: simf_alu.f
+incdir+verilog
verilog/simf_isa_pkg.sv
verilog/simf_alu_pkg.sv
verilog/simf_decode.sv
verilog/simf_fcmp_stage.sv
verilog/simf_result_stage.sv
verilog/simf_alu.sv
dv/simf_alu_asserts.sv
dv/simf_alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the simf_alu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f simf_alu.f --top-module simf_alu_tb -o simf_alu_sim

./obj_dir/simf_alu_sim
